// ==== logic/cpu_pkg.sv ====
/*
 * Shared definitions for the four-stage integer core.
 * ISA field types, opcode encodings, memory sizes and the host window base.
 * Every stage takes what it needs through a wildcard import.
 */
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;     // data and instruction word
    typedef logic [3:0]  reg_sel_t;  // register number
    typedef logic [15:0] addr_t;     // byte address

    // branch and jump share upper nibble 3
    typedef enum logic [7:0] {
        NOP  = 8'h00,
        ADD  = 8'h01,
        SUB  = 8'h02,
        AND  = 8'h03,
        OR   = 8'h04,
        XOR  = 8'h05,
        ADDI = 8'h11,
        LW   = 8'h81,
        SW   = 8'h83,
        BEQ  = 8'h31,
        BNE  = 8'h33,
        JMP  = 8'h3D
    } opcode_t;

    // register form: op rd rs rt
    typedef struct packed {
        opcode_t     op;
        reg_sel_t    rd;
        reg_sel_t    rs;
        reg_sel_t    rt;
        logic [11:0] unused;
    } instr_reg_t;

    // immediate form: op rd rs imm16
    typedef struct packed {
        opcode_t     op;
        reg_sel_t    rd;
        reg_sel_t    rs;
        logic [15:0] imm;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_t;

    localparam int    REG_COUNT   = 16;
    localparam int    IMEM_WORDS  = 256;
    localparam int    IMEM_AW     = $clog2(IMEM_WORDS);
    localparam int    DMEM_WORDS  = 64;
    localparam int    DMEM_AW     = $clog2(DMEM_WORDS);
    localparam addr_t HOST_BASE   = 16'h9000;  // stores from here go to the host
    localparam addr_t PC_STEP     = 16'd4;
    localparam int    SCORE_DEPTH = 3;         // slots between decode and the regfile

endpackage

`default_nettype wire

// ==== logic/pipe_if.sv ====
/*
 * Pipeline slot bundles between the core stages.
 * dec_ex_if carries one issued instruction from decode into execute,
 * ex_res_if carries the executed slot on into the result stage.
 */
`default_nettype none
`timescale 1ns/1ns

interface dec_ex_if
    import cpu_pkg::*;
();
    logic     valid;
    opcode_t  op;
    reg_sel_t rd;
    logic     wrt_en;   // slot writes rd at writeback
    word_t    src_a;
    word_t    src_b;    // register value, store data for SW
    word_t    imm;      // already sign extended

    modport dec (output valid, op, rd, wrt_en, src_a, src_b, imm);
    modport ex  (input  valid, op, rd, wrt_en, src_a, src_b, imm);
endinterface

interface ex_res_if
    import cpu_pkg::*;
();
    logic     valid;
    opcode_t  op;
    reg_sel_t rd;
    logic     wrt_en;
    word_t    alu_result;  // doubles as the memory address
    word_t    store_data;

    modport ex  (output valid, op, rd, wrt_en, alu_result, store_data);
    modport res (input  valid, op, rd, wrt_en, alu_result, store_data);
endinterface

`default_nettype wire

// ==== logic/fetch_stage.sv ====
/*
 * Fetch stage with the program counter and instruction memory.
 * While run is low the PC sits at zero and the program port loads words
 * by word index. Once running, one word per cycle goes to decode.
 */
`default_nettype none
`timescale 1ns/1ns

module fetch_stage
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  run,
    input  logic  hold,
    input  logic  redirect_en,
    input  addr_t redirect_pc,
    input  logic  prog_wrt_en,
    input  addr_t prog_addr,   // instruction word index
    input  word_t prog_data,
    output word_t instr,
    output logic  instr_valid
);

    word_t imem [IMEM_WORDS];
    addr_t pc;

    logic [IMEM_AW-1:0] pc_idx;
    logic               advance;

    assign pc_idx  = pc[2 +: IMEM_AW];   // byte PC to word index
    assign advance = run && !hold && !redirect_en;

    // program load, only while stopped
    always_ff @(posedge clk) begin
        if (!run && prog_wrt_en) begin
            imem[prog_addr[IMEM_AW-1:0]] <= prog_data;
        end
    end

    ////////////////////////////////////////
    // pc and fetch register valid
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= '0;
            instr_valid <= 1'b0;
        end else if (redirect_en) begin
            pc          <= redirect_pc;
            instr_valid <= 1'b0;   // drop the wrong-path word
        end else if (!run) begin
            pc          <= '0;
            instr_valid <= 1'b0;
        end else if (!hold) begin
            pc          <= pc + PC_STEP;
            instr_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            instr <= imem[pc_idx];
        end
    end

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
/*
 * Decode stage with the register file and the in-flight scoreboard.
 * A word is issued into the execute slot only when none of its sources
 * is still pending and no branch is unresolved; otherwise hold is raised
 * and a bubble goes down the pipe. There is no forwarding.
 */
`default_nettype none
`timescale 1ns/1ns

module decode_stage
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  word_t    instr,
    input  logic     instr_valid,
    input  logic     wb_en,
    input  reg_sel_t wb_sel,
    input  word_t    wb_data,
    output logic     hold,
    dec_ex_if.dec    dx
);

    instr_t   iw;
    opcode_t  op_d;
    reg_sel_t sel_a, sel_b;
    logic     use_a, use_b, writes_rd, is_branch;
    logic     hazard, issue;
    logic [1:0] br_cnt;   // cycles left until the branch resolves

    word_t    rf [REG_COUNT];
    logic     pend_vld [SCORE_DEPTH];
    reg_sel_t pend_rd  [SCORE_DEPTH];

    assign iw    = instr;
    assign sel_a = iw.r.rs;
    assign sel_b = (op_d == SW) ? iw.r.rd : iw.r.rt;   // stores read rd as data

    always_comb begin
        op_d      = iw.r.op;
        use_a     = 1'b1;
        use_b     = 1'b0;
        writes_rd = 1'b0;
        is_branch = 1'b0;
        case (iw.r.op)
            ADD, SUB, AND, OR, XOR: begin
                use_b     = 1'b1;
                writes_rd = 1'b1;
            end
            ADDI, LW:      writes_rd = 1'b1;
            SW:            use_b     = 1'b1;
            BEQ, BNE, JMP: is_branch = 1'b1;
            default: begin   // NOP and unknown codes
                op_d  = NOP;
                use_a = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////
    // hazard check against the scoreboard
    ////////////////////////////////////////
    always_comb begin
        hazard = 1'b0;
        for (int i = 0; i < SCORE_DEPTH; i++) begin
            if (pend_vld[i] && use_a && sel_a != '0 && pend_rd[i] == sel_a) hazard = 1'b1;
            if (pend_vld[i] && use_b && sel_b != '0 && pend_rd[i] == sel_b) hazard = 1'b1;
        end
    end

    assign issue = instr_valid && !hazard && (br_cnt == 2'd0);
    assign hold  = instr_valid && (hazard || br_cnt != 2'd0);

    // regfile, written at the edge
    always_ff @(posedge clk) begin
        if (wb_en) rf[wb_sel] <= wb_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            br_cnt    <= 2'd0;
            dx.valid  <= 1'b0;
            dx.wrt_en <= 1'b0;
            for (int i = 0; i < SCORE_DEPTH; i++) pend_vld[i] <= 1'b0;
        end else begin
            if (issue && is_branch) br_cnt <= 2'd2;
            else if (br_cnt != 2'd0) br_cnt <= br_cnt - 2'd1;
            dx.valid    <= issue;
            dx.wrt_en   <= issue && writes_rd;
            pend_vld[0] <= issue && writes_rd && iw.r.rd != '0;   // r0 never pending
            for (int i = 1; i < SCORE_DEPTH; i++) pend_vld[i] <= pend_vld[i-1];
        end
    end

    always_ff @(posedge clk) begin
        pend_rd[0] <= iw.r.rd;
        for (int i = 1; i < SCORE_DEPTH; i++) pend_rd[i] <= pend_rd[i-1];
        dx.op    <= op_d;
        dx.rd    <= iw.r.rd;
        dx.src_a <= (sel_a == '0) ? '0 : rf[sel_a];   // r0 reads zero
        dx.src_b <= (sel_b == '0) ? '0 : rf[sel_b];
        dx.imm   <= {{16{iw.i.imm[15]}}, iw.i.imm};
    end

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
/*
 * Execute stage: ALU, zero flag register and branch resolution.
 * A taken branch or a jump in the execute slot raises redirect_en in the
 * same cycle so fetch can load the target at the next edge.
 */
`default_nettype none
`timescale 1ns/1ns

module execute_stage
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    dec_ex_if.ex     dx,
    ex_res_if.ex     xr,
    output logic     redirect_en,
    output addr_t    redirect_pc
);

    word_t alu_result;
    logic  upd_zf;    // op writes the zero flag
    logic  zf;
    logic  taken;

    ////////////////////////////////////////
    // alu
    ////////////////////////////////////////
    always_comb begin
        upd_zf = 1'b1;
        case (dx.op)
            ADD:     alu_result = dx.src_a + dx.src_b;
            SUB:     alu_result = dx.src_a - dx.src_b;
            AND:     alu_result = dx.src_a & dx.src_b;
            OR:      alu_result = dx.src_a | dx.src_b;
            XOR:     alu_result = dx.src_a ^ dx.src_b;
            ADDI:    alu_result = dx.src_a + dx.imm;
            default: begin
                // address and branch target sum
                alu_result = dx.src_a + dx.imm;
                upd_zf     = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            zf <= 1'b0;
        end else if (dx.valid && upd_zf) begin
            zf <= (alu_result == '0);
        end
    end

    // branch conditions read the held flag
    always_comb begin
        case (dx.op)
            BEQ:     taken = zf;
            BNE:     taken = !zf;
            JMP:     taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect_en = dx.valid && taken;
    assign redirect_pc = alu_result[15:0];

    ////////////////////////////////////////
    // execute output register
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xr.valid  <= 1'b0;
            xr.wrt_en <= 1'b0;
        end else begin
            xr.valid  <= dx.valid;
            xr.wrt_en <= dx.valid && dx.wrt_en;
        end
    end

    always_ff @(posedge clk) begin
        xr.op         <= dx.op;
        xr.rd         <= dx.rd;
        xr.alu_result <= alu_result;
        xr.store_data <= dx.src_b;
    end

endmodule

`default_nettype wire

// ==== logic/result_stage.sv ====
/*
 * Result stage: data memory, host store window and writeback register.
 * Stores at or above HOST_BASE leave the core as a one-cycle host write,
 * lower stores and all loads use the local data memory.
 */
`default_nettype none
`timescale 1ns/1ns

module result_stage
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    ex_res_if.res    xr,
    output logic     wb_en,
    output reg_sel_t wb_sel,
    output word_t    wb_data,
    output logic     host_wrt_en,
    output addr_t    host_addr,
    output word_t    host_data
);

    word_t dmem [DMEM_WORDS];

    addr_t              mem_addr;
    logic [DMEM_AW-1:0] mem_idx;
    logic               is_store, to_host;

    assign mem_addr = xr.alu_result[15:0];
    assign mem_idx  = mem_addr[2 +: DMEM_AW];   // word aligned
    assign is_store = xr.valid && (xr.op == SW);
    assign to_host  = (mem_addr >= HOST_BASE);

    always_ff @(posedge clk) begin
        if (is_store && !to_host) dmem[mem_idx] <= xr.store_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en       <= 1'b0;
            host_wrt_en <= 1'b0;
        end else begin
            wb_en       <= xr.valid && xr.wrt_en;
            host_wrt_en <= is_store && to_host;   // never stalled
        end
    end

    always_ff @(posedge clk) begin
        wb_sel    <= xr.rd;
        wb_data   <= (xr.op == LW) ? dmem[mem_idx] : xr.alu_result;
        host_addr <= mem_addr;
        host_data <= xr.store_data;
    end

endmodule

`default_nettype wire

// ==== logic/cpu_core.sv ====
/*
 * Top level of the pipelined core.
 * Load a program through the prog_ port with run low, then raise run.
 * Results leave only through host_wrt_en strobes.
 */
`default_nettype none
`timescale 1ns/1ns

module cpu_core
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  run,
    input  logic  prog_wrt_en,
    input  addr_t prog_addr,
    input  word_t prog_data,
    output logic  host_wrt_en,
    output addr_t host_addr,
    output word_t host_data
);

    logic     hold;
    logic     redirect_en;
    addr_t    redirect_pc;
    word_t    instr;
    logic     instr_valid;
    logic     wb_en;
    reg_sel_t wb_sel;
    word_t    wb_data;

    dec_ex_if dx_bus ();
    ex_res_if xr_bus ();

    fetch_stage u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .hold        (hold),
        .redirect_en (redirect_en),
        .redirect_pc (redirect_pc),
        .prog_wrt_en (prog_wrt_en),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .instr       (instr),
        .instr_valid (instr_valid)
    );

    decode_stage u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .wb_en       (wb_en),
        .wb_sel      (wb_sel),
        .wb_data     (wb_data),
        .hold        (hold),
        .dx          (dx_bus)
    );

    execute_stage u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .dx          (dx_bus),
        .xr          (xr_bus),
        .redirect_en (redirect_en),
        .redirect_pc (redirect_pc)
    );

    result_stage u_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .xr          (xr_bus),
        .wb_en       (wb_en),
        .wb_sel      (wb_sel),
        .wb_data     (wb_data),
        .host_wrt_en (host_wrt_en),
        .host_addr   (host_addr),
        .host_data   (host_data)
    );

endmodule

`default_nettype wire

// ==== tests/cpu_core_checker.sv ====
/*
 * Concurrent checks on the host write port of the core.
 * Bound into cpu_core, so it rides along with the testbench's dut_i.
 */
`default_nettype none
`timescale 1ns/1ns

module cpu_core_checker
    import cpu_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  run,
    input logic  host_wrt_en,
    input addr_t host_addr
);

    ////////////////////////////////////////
    // host port rules
    ////////////////////////////////////////
    host_pulse_single : assert property (@(posedge clk) disable iff (!rst_n)
        host_wrt_en |=> !host_wrt_en)
        else $error("host_wrt_en stayed high for more than one cycle");

    host_addr_window : assert property (@(posedge clk) disable iff (!rst_n)
        host_wrt_en |-> (host_addr >= HOST_BASE))
        else $error("host write below the host window base");

    // core is stopped, nothing may leave it
    host_quiet_stopped : assert property (@(posedge clk) disable iff (!rst_n)
        !run |-> !host_wrt_en)
        else $error("host write while run is low");

endmodule

bind cpu_core cpu_core_checker checker_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .run         (run),
    .host_wrt_en (host_wrt_en),
    .host_addr   (host_addr)
);

`default_nettype wire

// ==== tests/cpu_core_tb.sv ====
/*
 * Directed testbench for the pipelined core.
 * Each test resets the core, loads a small program with run low, raises
 * run and compares the host writes against values worked out here.
 */
`default_nettype none
`timescale 1ns/1ns

module cpu_core_tb
    import cpu_pkg::*;
();

    localparam int WAIT_LIMIT   = 200;   // cycles allowed per host write
    localparam int QUIET_CYCLES = 60;

    logic  clk;
    logic  rst_n;
    logic  run;
    logic  prog_wrt_en;
    addr_t prog_addr;
    word_t prog_data;
    logic  host_wrt_en;
    addr_t host_addr;
    word_t host_data;

    word_t       prog [$];
    logic [47:0] host_q [$];   // {addr, data} per host write
    logic [31:0] lfsr = 32'h3c235f19;
    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;

    cpu_core dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .prog_wrt_en (prog_wrt_en),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .host_wrt_en (host_wrt_en),
        .host_addr   (host_addr),
        .host_data   (host_data)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (host_wrt_en) begin
            host_q.push_back({host_addr, host_data});
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    function automatic logic [15:0] rand16();
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < 16; i++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);   // galois step
        end
        return v;
    endfunction

    function automatic word_t sext(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic word_t reg_word(input opcode_t op, input reg_sel_t rd,
                                       input reg_sel_t rs, input reg_sel_t rt);
        return {op, rd, rs, rt, 12'h000};
    endfunction

    function automatic word_t imm_word(input opcode_t op, input reg_sel_t rd,
                                       input reg_sel_t rs, input logic [15:0] imm);
        return {op, rd, rs, imm};
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        rst_n       <= 1'b0;
        run         <= 1'b0;
        prog_wrt_en <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        host_q.delete();
    endtask

    // reset, write the program word by word, then start
    task automatic load_and_run();
        apply_reset();
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            prog_wrt_en <= 1'b1;
            prog_addr   <= 16'(i);
            prog_data   <= prog[i];
        end
        @(posedge clk);
        prog_wrt_en <= 1'b0;
        run         <= 1'b1;
    endtask

    task automatic expect_host_write(input string name, input addr_t exp_addr,
                                     input word_t exp_data);
        int          waited;
        logic [47:0] got;
        waited = 0;
        while (host_q.size() == 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (host_q.size() != 0) else begin
            timeouts++;
            $display("%s: no host write arrived within %0d cycles", name, WAIT_LIMIT);
        end
        if (host_q.size() != 0) begin
            got = host_q.pop_front();
            checks++;
            assert (got[47:32] == exp_addr) else begin
                errors++;
                $display("error: %s host_addr expected %h actual %h",
                         name, exp_addr, got[47:32]);
            end
            assert (got[31:0] == exp_data) else begin
                errors++;
                $display("error: %s host_data expected %h actual %h",
                         name, exp_data, got[31:0]);
            end
        end
    endtask

    task automatic expect_silence(input string name);
        int waited;
        waited = 0;
        while (host_q.size() == 0 && waited < QUIET_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (host_q.size() == 0) else begin
            errors++;
            $display("%s: unexpected host write to %h", name, host_q[0][47:32]);
        end
        host_q.delete();
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////
    task automatic arithmetic_ops();
        opcode_t     ops [5];
        word_t       expv [5];
        logic [15:0] a, b;
        a    = rand16();
        b    = rand16();
        ops  = '{ADD, SUB, AND, OR, XOR};
        expv = '{sext(a) + sext(b), sext(a) - sext(b), sext(a) & sext(b),
                 sext(a) | sext(b), sext(a) ^ sext(b)};
        prog.delete();
        prog.push_back(imm_word(ADDI, 4'd1, 4'd0, a));
        prog.push_back(imm_word(ADDI, 4'd2, 4'd0, b));
        for (int k = 0; k < 5; k++) begin
            prog.push_back(reg_word(ops[k], 4'(k + 3), 4'd1, 4'd2));
            prog.push_back(imm_word(SW, 4'(k + 3), 4'd0, 16'h9000 + 16'(4 * k)));
        end
        prog.push_back(imm_word(JMP, 4'd0, 4'd0, 16'd48));   // word 12, spin
        load_and_run();
        for (int k = 0; k < 5; k++) begin
            expect_host_write("arithmetic", 16'h9000 + 16'(4 * k), expv[k]);
        end
        expect_silence("arithmetic");
    endtask

    task automatic dependency_chain();
        logic [15:0] a, b;
        word_t       v1, v2, v3, v4;
        a  = rand16();
        b  = rand16();
        v1 = sext(a);
        v2 = v1 + sext(b);
        v3 = v2 + v1;
        v4 = v3 + v2;
        prog.delete();
        prog.push_back(imm_word(ADDI, 4'd1, 4'd0, a));
        prog.push_back(imm_word(ADDI, 4'd2, 4'd1, b));
        prog.push_back(reg_word(ADD, 4'd3, 4'd2, 4'd1));
        prog.push_back(reg_word(ADD, 4'd4, 4'd3, 4'd2));
        prog.push_back(reg_word(ADD, 4'd5, 4'd4, 4'd3));
        prog.push_back(imm_word(SW, 4'd5, 4'd0, 16'h9000));
        prog.push_back(imm_word(JMP, 4'd0, 4'd0, 16'd24));
        load_and_run();
        expect_host_write("dependency", 16'h9000, v4 + v3);
        expect_silence("dependency");
    endtask

    task automatic memory_roundtrip();
        logic [15:0] a, b;
        a = rand16();
        b = rand16();
        prog.delete();
        prog.push_back(imm_word(ADDI, 4'd1, 4'd0, a));
        prog.push_back(imm_word(ADDI, 4'd2, 4'd0, b));
        prog.push_back(imm_word(SW, 4'd1, 4'd0, 16'h0020));   // local data memory
        prog.push_back(imm_word(SW, 4'd2, 4'd0, 16'h0024));
        prog.push_back(imm_word(LW, 4'd3, 4'd0, 16'h0020));
        prog.push_back(imm_word(LW, 4'd4, 4'd0, 16'h0024));
        prog.push_back(imm_word(SW, 4'd3, 4'd0, 16'h9000));
        prog.push_back(32'h0000_0000);   // nop keeps host pulses apart
        prog.push_back(imm_word(SW, 4'd4, 4'd0, 16'h9004));
        prog.push_back(imm_word(JMP, 4'd0, 4'd0, 16'd36));
        load_and_run();
        expect_host_write("memory", 16'h9000, sext(a));
        expect_host_write("memory", 16'h9004, sext(b));
        expect_silence("memory");
    endtask

    task automatic branch_skips();
        logic [15:0] v, w;
        v = rand16();
        w = rand16();
        if (w == v) w = ~v;
        prog.delete();
        prog.push_back(imm_word(ADDI, 4'd1, 4'd0, v));
        prog.push_back(imm_word(ADDI, 4'd2, 4'd0, v));
        prog.push_back(imm_word(ADDI, 4'd3, 4'd0, w));
        prog.push_back(reg_word(SUB, 4'd4, 4'd1, 4'd2));      // equal, zero set
        prog.push_back(imm_word(BEQ, 4'd0, 4'd0, 16'd24));   // taken to word 6
        prog.push_back(imm_word(SW, 4'd1, 4'd0, 16'h9000));
        prog.push_back(reg_word(SUB, 4'd5, 4'd1, 4'd3));
        prog.push_back(imm_word(BEQ, 4'd0, 4'd0, 16'd36));   // falls through
        prog.push_back(imm_word(SW, 4'd3, 4'd0, 16'h9004));
        prog.push_back(reg_word(SUB, 4'd6, 4'd1, 4'd3));
        prog.push_back(imm_word(BNE, 4'd0, 4'd0, 16'd48));   // taken to word 12
        prog.push_back(imm_word(SW, 4'd1, 4'd0, 16'h9008));
        prog.push_back(reg_word(SUB, 4'd7, 4'd1, 4'd2));
        prog.push_back(imm_word(BNE, 4'd0, 4'd0, 16'd60));   // falls through
        prog.push_back(imm_word(SW, 4'd2, 4'd0, 16'h900C));
        prog.push_back(imm_word(JMP, 4'd0, 4'd0, 16'd60));
        load_and_run();
        expect_host_write("branches", 16'h9004, sext(w));
        expect_host_write("branches", 16'h900C, sext(v));
        expect_silence("branches");
    endtask

    task automatic jump_over();
        logic [15:0] v;
        v = rand16();
        prog.delete();
        prog.push_back(imm_word(ADDI, 4'd1, 4'd0, v));
        prog.push_back(imm_word(JMP, 4'd0, 4'd0, 16'd12));
        prog.push_back(imm_word(SW, 4'd1, 4'd0, 16'h9000));   // never reached
        prog.push_back(imm_word(SW, 4'd1, 4'd0, 16'h9004));
        prog.push_back(imm_word(JMP, 4'd0, 4'd0, 16'd16));    // jump to self
        load_and_run();
        expect_host_write("jump", 16'h9004, sext(v));
        expect_silence("jump");
    endtask

    initial begin
        rst_n       <= 1'b0;
        run         <= 1'b0;
        prog_wrt_en <= 1'b0;
        prog_addr   <= '0;
        prog_data   <= '0;
        arithmetic_ops();
        dependency_chain();
        memory_roundtrip();
        branch_skips();
        jump_over();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu_core.f ====
logic/cpu_pkg.sv
logic/pipe_if.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/cpu_core.sv
tests/cpu_core_checker.sv
tests/cpu_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the core testbench with Verilator.
# A build error, a simulator abort or a failing check all end in a failing status.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f cpu_core.f --top-module cpu_core_tb -o cpu_core_sim &&
    ./obj_dir/cpu_core_sim > sim.log 2>&1 ||
    echo "RESULT: FAIL" >> sim.log
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0
